//--- src/axi_ram_cfg.svh
// axi_ram configuration: bus field widths, request FIFO depth and memory size
`ifndef AXI_RAM_CFG_SVH
`define AXI_RAM_CFG_SVH

`define AXI_ID_WIDTH   4     // transaction id
`define AXI_ADDR_WIDTH 16    // byte address
`define AXI_DATA_WIDTH 32    // one word per beat
`define AXI_LEN_WIDTH  8     // beats = len + 1

`define RAM_WORDS      256
`define RAM_AW         8     // log2 of RAM_WORDS

`define REQ_FIFO_DEPTH 4

`endif

//--- src/axi_pkg.sv
// axi_pkg: bus-level encodings for burst type and response code
`default_nettype none

package axi_pkg;

   typedef enum logic [1:0] {
      FIXED = 2'b00,
      INCR  = 2'b01,
      WRAP  = 2'b10,
      RSVD  = 2'b11
   } burst_e;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,   // not produced here
      SLVERR = 2'b10,
      DECERR = 2'b11    // not produced here
   } resp_e;

endpackage

`default_nettype wire

//--- src/ram_pkg.sv
// ram_pkg: state encodings for the write and read burst machines
`default_nettype none

package ram_pkg;

   typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

   typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_SEND} rd_state_e;

endpackage

`default_nettype wire

//--- src/req_fifo.sv
// req_fifo: synchronous circular-buffer FIFO with valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  wire logic             clk,
   input  wire logic             rstn,
   input  wire logic             in_valid,
   input  wire logic [WIDTH-1:0] in_data,
   output logic                  in_ready,
   output logic                  out_valid,
   output logic      [WIDTH-1:0] out_data,
   input  wire logic             out_ready
);

   localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PW-1:0]    wr_ptr;
   logic [PW-1:0]    rd_ptr;
   logic [PW:0]      count;
   logic             push;
   logic             pop;

   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;
   assign in_ready  = count < (PW+1)'(DEPTH);
   assign out_valid = count != '0;
   assign out_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == PW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (pop) rd_ptr <= (rd_ptr == PW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop) count <= count + 1'b1;
         else if (pop && !push) count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- src/burst_counter.sv
// burst_counter: tracks word address and beats left for one burst
`timescale 1ns/1ps
`default_nettype none
`include "axi_ram_cfg.svh"

module burst_counter (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire logic                       load,
   input  wire logic [`AXI_ADDR_WIDTH-1:0] start_addr,
   input  wire logic [`AXI_LEN_WIDTH-1:0]  len,
   input  wire axi_pkg::burst_e            burst,
   input  wire logic                       step,
   output logic      [`RAM_AW-1:0]         word_addr,
   output logic                            last
);

   logic [`RAM_AW-1:0]        addr_q;
   logic [`AXI_LEN_WIDTH-1:0] remain_q;
   axi_pkg::burst_e           burst_q;

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         addr_q   <= '0;
         remain_q <= '0;
         burst_q  <= axi_pkg::FIXED;
      end else if (load) begin
         addr_q   <= start_addr[`RAM_AW+1:2];   // drop byte offset, wrap in memory
         remain_q <= len;
         burst_q  <= burst;
      end else if (step) begin
         remain_q <= remain_q - 1'b1;
         if (burst_q == axi_pkg::INCR) addr_q <= addr_q + 1'b1;   // fixed holds word
      end
   end

   assign word_addr = addr_q;
   assign last      = remain_q == '0;

endmodule

`default_nettype wire

//--- src/ram_writer.sv
// ram_writer: accepts a write burst on AW/W, writes memory, returns B
`timescale 1ns/1ps
`default_nettype none
`include "axi_ram_cfg.svh"

module ram_writer (
   input  wire logic                         clk,
   input  wire logic                         rstn,
   input  wire logic [`AXI_ID_WIDTH-1:0]     aw_id,
   input  wire logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
   input  wire logic [`AXI_LEN_WIDTH-1:0]    aw_len,
   input  wire axi_pkg::burst_e              aw_burst,
   input  wire logic                         aw_valid,
   output logic                              aw_ready,
   input  wire logic [`AXI_DATA_WIDTH-1:0]   w_data,
   input  wire logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
   input  wire logic                         w_last,
   input  wire logic                         w_valid,
   output logic                              w_ready,
   output logic      [`AXI_ID_WIDTH-1:0]     b_id,
   output axi_pkg::resp_e                    b_resp,
   output logic                              b_valid,
   input  wire logic                         b_ready,
   output logic                              cnt_load,
   output logic                              cnt_step,
   input  wire logic [`RAM_AW-1:0]           cnt_addr,
   input  wire logic                         cnt_last,
   output logic                              wr_en,
   output logic      [`RAM_AW-1:0]           wr_addr,
   output logic      [`AXI_DATA_WIDTH-1:0]   wr_data,
   output logic      [`AXI_DATA_WIDTH/8-1:0] wr_strb
);

   ram_pkg::wr_state_e         state;
   logic [`AXI_ID_WIDTH-1:0]   id_q;
   logic                       ok_q;    // fixed or incr
   logic                       err_q;   // w_last off the counted end
   logic                       w_hs;

   assign aw_ready = state == ram_pkg::WR_IDLE;
   assign w_ready  = state == ram_pkg::WR_DATA;
   assign b_valid  = state == ram_pkg::WR_RESP;
   assign w_hs     = w_valid && w_ready;

   assign cnt_load = aw_valid && aw_ready;   // counter takes aw_addr, aw_len
   assign cnt_step = w_hs;
   assign wr_en    = w_hs && ok_q;
   assign wr_addr  = cnt_addr;
   assign wr_data  = w_data;
   assign wr_strb  = w_strb;

   assign b_id   = id_q;
   assign b_resp = (ok_q && !err_q) ? axi_pkg::OKAY : axi_pkg::SLVERR;

   always_ff @(posedge clk) begin
      if (cnt_load) id_q <= aw_id;
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state <= ram_pkg::WR_IDLE;
         ok_q  <= 1'b0;
         err_q <= 1'b0;
      end else begin
         case (state)
            ram_pkg::WR_IDLE: if (cnt_load) begin
               ok_q  <= (aw_burst == axi_pkg::FIXED) || (aw_burst == axi_pkg::INCR);
               err_q <= 1'b0;
               state <= ram_pkg::WR_DATA;
            end
            ram_pkg::WR_DATA: if (w_hs) begin
               if (w_last != cnt_last) err_q <= 1'b1;
               if (w_last) state <= ram_pkg::WR_RESP;   // burst ends on w_last
            end
            ram_pkg::WR_RESP: if (b_ready) state <= ram_pkg::WR_IDLE;
            default: state <= ram_pkg::WR_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/ram_reader.sv
// ram_reader: serves a read burst from AR, one fetch and one send per beat on R
`timescale 1ns/1ps
`default_nettype none
`include "axi_ram_cfg.svh"

module ram_reader (
   input  wire logic                       clk,
   input  wire logic                       rstn,
   input  wire logic [`AXI_ID_WIDTH-1:0]   ar_id,
   input  wire logic [`AXI_ADDR_WIDTH-1:0] ar_addr,
   input  wire logic [`AXI_LEN_WIDTH-1:0]  ar_len,
   input  wire axi_pkg::burst_e            ar_burst,
   input  wire logic                       ar_valid,
   output logic                            ar_ready,
   output logic      [`AXI_ID_WIDTH-1:0]   r_id,
   output logic      [`AXI_DATA_WIDTH-1:0] r_data,
   output axi_pkg::resp_e                  r_resp,
   output logic                            r_last,
   output logic                            r_valid,
   input  wire logic                       r_ready,
   output logic                            cnt_load,
   output logic                            cnt_step,
   input  wire logic [`RAM_AW-1:0]         cnt_addr,
   input  wire logic                       cnt_last,
   output logic                            rd_en,
   output logic      [`RAM_AW-1:0]         rd_addr,
   input  wire logic [`AXI_DATA_WIDTH-1:0] rd_data
);

   ram_pkg::rd_state_e       state;
   logic [`AXI_ID_WIDTH-1:0] id_q;
   logic                     ok_q;   // fixed or incr
   logic                     r_hs;

   assign ar_ready = state == ram_pkg::RD_IDLE;
   assign r_valid  = state == ram_pkg::RD_SEND;
   assign r_hs     = r_valid && r_ready;

   assign cnt_load = ar_valid && ar_ready;   // counter takes ar_addr, ar_len
   assign cnt_step = r_hs;
   assign rd_en    = (state == ram_pkg::RD_FETCH) && ok_q;
   assign rd_addr  = cnt_addr;

   // rd_data is held by the memory until the next fetch
   assign r_id   = id_q;
   assign r_data = ok_q ? rd_data : '0;
   assign r_resp = ok_q ? axi_pkg::OKAY : axi_pkg::SLVERR;
   assign r_last = r_valid && cnt_last;

   always_ff @(posedge clk) begin
      if (cnt_load) id_q <= ar_id;
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state <= ram_pkg::RD_IDLE;
         ok_q  <= 1'b0;
      end else begin
         case (state)
            ram_pkg::RD_IDLE: if (cnt_load) begin
               ok_q  <= (ar_burst == axi_pkg::FIXED) || (ar_burst == axi_pkg::INCR);
               state <= ram_pkg::RD_FETCH;
            end
            ram_pkg::RD_FETCH: state <= ram_pkg::RD_SEND;
            ram_pkg::RD_SEND: if (r_hs) begin
               state <= cnt_last ? ram_pkg::RD_IDLE : ram_pkg::RD_FETCH;
            end
            default: state <= ram_pkg::RD_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/ram_array.sv
// ram_array: word memory with byte-lane write enables and a registered read port
`timescale 1ns/1ps
`default_nettype none
`include "axi_ram_cfg.svh"

module ram_array (
   input  wire logic                         clk,
   input  wire logic                         wr_en,
   input  wire logic [`RAM_AW-1:0]           wr_addr,
   input  wire logic [`AXI_DATA_WIDTH-1:0]   wr_data,
   input  wire logic [`AXI_DATA_WIDTH/8-1:0] wr_strb,
   input  wire logic                         rd_en,
   input  wire logic [`RAM_AW-1:0]           rd_addr,
   output logic      [`AXI_DATA_WIDTH-1:0]   rd_data
);

   logic [`AXI_DATA_WIDTH-1:0] mem [`RAM_WORDS];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < `AXI_DATA_WIDTH/8; b++) begin
            if (wr_strb[b]) mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) rd_data <= mem[rd_addr];   // holds between fetches
   end

endmodule

`default_nettype wire

//--- src/axi_ram.sv
// axi_ram: burst memory slave with request FIFOs, write and read machines
`timescale 1ns/1ps
`default_nettype none
`include "axi_ram_cfg.svh"

module axi_ram (
   input  wire logic                         clk,
   input  wire logic                         rstn,
   input  wire logic [`AXI_ID_WIDTH-1:0]     aw_id,
   input  wire logic [`AXI_ADDR_WIDTH-1:0]   aw_addr,
   input  wire logic [`AXI_LEN_WIDTH-1:0]    aw_len,
   input  wire logic [1:0]                   aw_burst,
   input  wire logic                         aw_valid,
   output logic                              aw_ready,
   input  wire logic [`AXI_DATA_WIDTH-1:0]   w_data,
   input  wire logic [`AXI_DATA_WIDTH/8-1:0] w_strb,
   input  wire logic                         w_last,
   input  wire logic                         w_valid,
   output logic                              w_ready,
   output logic      [`AXI_ID_WIDTH-1:0]     b_id,
   output logic      [1:0]                   b_resp,
   output logic                              b_valid,
   input  wire logic                         b_ready,
   input  wire logic [`AXI_ID_WIDTH-1:0]     ar_id,
   input  wire logic [`AXI_ADDR_WIDTH-1:0]   ar_addr,
   input  wire logic [`AXI_LEN_WIDTH-1:0]    ar_len,
   input  wire logic [1:0]                   ar_burst,
   input  wire logic                         ar_valid,
   output logic                              ar_ready,
   output logic      [`AXI_ID_WIDTH-1:0]     r_id,
   output logic      [`AXI_DATA_WIDTH-1:0]   r_data,
   output logic      [1:0]                   r_resp,
   output logic                              r_last,
   output logic                              r_valid,
   input  wire logic                         r_ready
);

   localparam int AX_W = `AXI_ID_WIDTH + `AXI_ADDR_WIDTH + `AXI_LEN_WIDTH + 2;
   localparam int W_W  = `AXI_DATA_WIDTH + `AXI_DATA_WIDTH/8 + 1;

   // pop side of the request FIFOs
   logic [`AXI_ID_WIDTH-1:0]     awq_id, arq_id;
   logic [`AXI_ADDR_WIDTH-1:0]   awq_addr, arq_addr;
   logic [`AXI_LEN_WIDTH-1:0]    awq_len, arq_len;
   logic [1:0]                   awq_burst_bits, arq_burst_bits;
   axi_pkg::burst_e              awq_burst, arq_burst;
   logic                         awq_valid, awq_ready, arq_valid, arq_ready;
   logic [`AXI_DATA_WIDTH-1:0]   wq_data;
   logic [`AXI_DATA_WIDTH/8-1:0] wq_strb;
   logic                         wq_last, wq_valid, wq_ready;

   logic                         wc_load, wc_step, wc_last, rc_load, rc_step, rc_last;
   logic [`RAM_AW-1:0]           wc_addr, rc_addr;
   logic                         wr_en, rd_en;
   logic [`RAM_AW-1:0]           wr_addr, rd_addr;
   logic [`AXI_DATA_WIDTH-1:0]   wr_data, rd_data;
   logic [`AXI_DATA_WIDTH/8-1:0] wr_strb;

   assign awq_burst = axi_pkg::burst_e'(awq_burst_bits);
   assign arq_burst = axi_pkg::burst_e'(arq_burst_bits);

   req_fifo #(.WIDTH(AX_W), .DEPTH(`REQ_FIFO_DEPTH)) aw_fifo (
      .clk(clk), .rstn(rstn),
      .in_valid(aw_valid), .in_data({aw_id, aw_addr, aw_len, aw_burst}), .in_ready(aw_ready),
      .out_valid(awq_valid), .out_data({awq_id, awq_addr, awq_len, awq_burst_bits}),
      .out_ready(awq_ready)
   );

   req_fifo #(.WIDTH(W_W), .DEPTH(`REQ_FIFO_DEPTH)) w_fifo (
      .clk(clk), .rstn(rstn),
      .in_valid(w_valid), .in_data({w_data, w_strb, w_last}), .in_ready(w_ready),
      .out_valid(wq_valid), .out_data({wq_data, wq_strb, wq_last}), .out_ready(wq_ready)
   );

   req_fifo #(.WIDTH(AX_W), .DEPTH(`REQ_FIFO_DEPTH)) ar_fifo (
      .clk(clk), .rstn(rstn),
      .in_valid(ar_valid), .in_data({ar_id, ar_addr, ar_len, ar_burst}), .in_ready(ar_ready),
      .out_valid(arq_valid), .out_data({arq_id, arq_addr, arq_len, arq_burst_bits}),
      .out_ready(arq_ready)
   );

   burst_counter u_wr_cnt (
      .clk(clk), .rstn(rstn), .load(wc_load), .start_addr(awq_addr), .len(awq_len),
      .burst(awq_burst), .step(wc_step), .word_addr(wc_addr), .last(wc_last)
   );

   burst_counter u_rd_cnt (
      .clk(clk), .rstn(rstn), .load(rc_load), .start_addr(arq_addr), .len(arq_len),
      .burst(arq_burst), .step(rc_step), .word_addr(rc_addr), .last(rc_last)
   );

   ram_writer u_writer (
      .clk(clk), .rstn(rstn),
      .aw_id(awq_id), .aw_addr(awq_addr), .aw_len(awq_len), .aw_burst(awq_burst),
      .aw_valid(awq_valid), .aw_ready(awq_ready),
      .w_data(wq_data), .w_strb(wq_strb), .w_last(wq_last),
      .w_valid(wq_valid), .w_ready(wq_ready),
      .b_id(b_id), .b_resp(b_resp), .b_valid(b_valid), .b_ready(b_ready),
      .cnt_load(wc_load), .cnt_step(wc_step), .cnt_addr(wc_addr), .cnt_last(wc_last),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb)
   );

   ram_reader u_reader (
      .clk(clk), .rstn(rstn),
      .ar_id(arq_id), .ar_addr(arq_addr), .ar_len(arq_len), .ar_burst(arq_burst),
      .ar_valid(arq_valid), .ar_ready(arq_ready),
      .r_id(r_id), .r_data(r_data), .r_resp(r_resp), .r_last(r_last),
      .r_valid(r_valid), .r_ready(r_ready),
      .cnt_load(rc_load), .cnt_step(rc_step), .cnt_addr(rc_addr), .cnt_last(rc_last),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
   );

   ram_array u_ram (
      .clk(clk),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
      .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
   );

endmodule

`default_nettype wire

//--- test/axi_ram_assert.sv
// axi_ram_assert: valid/ready protocol checks on the axi_ram channels
`timescale 1ns/1ps
`default_nettype none

module axi_ram_assert (
   input wire logic clk,
   input wire logic rstn,
   input wire logic aw_valid,
   input wire logic aw_ready,
   input wire logic w_valid,
   input wire logic w_ready,
   input wire logic b_valid,
   input wire logic b_ready,
   input wire logic ar_valid,
   input wire logic ar_ready,
   input wire logic r_valid,
   input wire logic r_ready,
   input wire logic r_last
);

   int fails = 0;

   // a raised valid holds until its transfer
   hold_aw: assert property (@(posedge clk) disable iff (!rstn)
                             aw_valid && !aw_ready |=> aw_valid)
      else begin
         fails++;
         $error("aw_valid dropped before aw_ready");
      end
   hold_w: assert property (@(posedge clk) disable iff (!rstn) w_valid && !w_ready |=> w_valid)
      else begin
         fails++;
         $error("w_valid dropped before w_ready");
      end
   hold_b: assert property (@(posedge clk) disable iff (!rstn) b_valid && !b_ready |=> b_valid)
      else begin
         fails++;
         $error("b_valid dropped before b_ready");
      end
   hold_ar: assert property (@(posedge clk) disable iff (!rstn)
                             ar_valid && !ar_ready |=> ar_valid)
      else begin
         fails++;
         $error("ar_valid dropped before ar_ready");
      end
   hold_r: assert property (@(posedge clk) disable iff (!rstn) r_valid && !r_ready |=> r_valid)
      else begin
         fails++;
         $error("r_valid dropped before r_ready");
      end

   reset_quiet: assert property (@(posedge clk) !rstn |-> !b_valid && !r_valid)
      else begin
         fails++;
         $error("response valid high during reset");
      end

   last_needs_valid: assert property (@(posedge clk) r_last |-> r_valid)
      else begin
         fails++;
         $error("r_last high without r_valid");
      end

endmodule

`default_nettype wire

//--- test/axi_ram_tb.sv
// axi_ram_tb: random burst traffic checked against a byte-array model of the memory
`timescale 1ns/1ps
`default_nettype none
`include "axi_ram_cfg.svh"

module axi_ram_tb;

   localparam int CLK_PERIOD      = 100;
   localparam int N_BURSTS        = 68;    // fill 2, incr 24, fixed 12, unsupported 18, w_last 12
   localparam int MAX_BEATS       = 256;
   localparam int WATCHDOG_CYCLES = N_BURSTS * MAX_BEATS * 8;   // two cycles a beat plus stalls

   logic                         clk;
   logic                         rstn;
   logic [`AXI_ID_WIDTH-1:0]     aw_id, ar_id, b_id, r_id;
   logic [`AXI_ADDR_WIDTH-1:0]   aw_addr, ar_addr;
   logic [`AXI_LEN_WIDTH-1:0]    aw_len, ar_len;
   logic [1:0]                   aw_burst, ar_burst, b_resp, r_resp;
   logic [`AXI_DATA_WIDTH-1:0]   w_data, r_data;
   logic [`AXI_DATA_WIDTH/8-1:0] w_strb;
   logic                         aw_valid, aw_ready, w_last, w_valid, w_ready;
   logic                         b_valid, b_ready, ar_valid, ar_ready;
   logic                         r_last, r_valid, r_ready;

   logic [7:0] model_mem [4*`RAM_WORDS];   // byte-addressed image of the memory
   int         errors = 0;
   int         checks = 0;
   int         tests  = 0;
   int         bursts = 0;

   axi_ram u_axi_ram (.*);

   bind axi_ram axi_ram_assert u_axi_ram_assert (
      .clk(clk), .rstn(rstn),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .w_valid(w_valid), .w_ready(w_ready),
      .b_valid(b_valid), .b_ready(b_ready), .ar_valid(ar_valid), .ar_ready(ar_ready),
      .r_valid(r_valid), .r_ready(r_ready), .r_last(r_last)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, a burst never completed");
      $display("** FAIL **");
      $finish;
   end

   function automatic logic [`AXI_ID_WIDTH-1:0] rand_id();
      logic [31:0] r;
      r = $urandom;
      return r[`AXI_ID_WIDTH-1:0];
   endfunction

   function automatic logic [`AXI_ADDR_WIDTH-1:0] rand_addr();
      logic [31:0] r;
      r = $urandom;
      return r[`AXI_ADDR_WIDTH-1:0];
   endfunction

   function automatic logic burst_ok(input logic [1:0] burst);
      return burst == axi_pkg::FIXED || burst == axi_pkg::INCR;
   endfunction

   // word index of beat i
   function automatic logic [`RAM_AW-1:0] beat_word(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                                                     input logic [1:0] burst, input int i);
      logic [`RAM_AW-1:0] start;
      start = addr[`RAM_AW+1:2];   // drop byte offset
      if (burst == axi_pkg::INCR) return start + i[`RAM_AW-1:0];   // wraps in memory
      return start;
   endfunction

   function automatic logic [31:0] model_word(input logic [`RAM_AW-1:0] w);
      return {model_mem[{w, 2'd3}], model_mem[{w, 2'd2}],
              model_mem[{w, 2'd1}], model_mem[{w, 2'd0}]};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic write_burst(input logic [`AXI_ID_WIDTH-1:0] id,
                              input logic [`AXI_ADDR_WIDTH-1:0] addr, input int len,
                              input logic [1:0] burst, input int nbeats, input bit full_strb);
      logic [31:0] data;
      logic [3:0]  strb;
      logic [1:0]  exp_resp;
      bursts++;
      aw_id    <= id;
      aw_addr  <= addr;
      aw_len   <= len[`AXI_LEN_WIDTH-1:0];
      aw_burst <= burst;
      aw_valid <= 1'b1;
      do @(posedge clk); while (!aw_ready);
      aw_valid <= 1'b0;
      for (int i = 0; i < nbeats; i++) begin
         data = $urandom;
         strb = full_strb ? 4'hf : 4'($urandom);
         w_data  <= data;
         w_strb  <= strb;
         w_last  <= (i == nbeats - 1);
         w_valid <= 1'b1;
         do @(posedge clk); while (!w_ready);
         if (burst_ok(burst)) begin
            for (int b = 0; b < 4; b++) begin
               if (strb[b]) model_mem[{beat_word(addr, burst, i), 2'(b)}] = data[b*8 +: 8];
            end
         end
      end
      w_valid <= 1'b0;
      w_last  <= 1'b0;
      exp_resp = (burst_ok(burst) && nbeats == len + 1) ? axi_pkg::OKAY : axi_pkg::SLVERR;
      do begin
         b_ready <= ($urandom % 4 != 0);   // withheld about one cycle in four
         @(posedge clk);
      end while (!(b_valid && b_ready));
      check_val("b_id", 32'(b_id), 32'(id));
      check_val("b_resp", 32'(b_resp), 32'(exp_resp));
      b_ready <= 1'b0;
   endtask

   task automatic read_burst(input logic [`AXI_ID_WIDTH-1:0] id,
                             input logic [`AXI_ADDR_WIDTH-1:0] addr, input int len,
                             input logic [1:0] burst);
      logic [31:0] exp_data;
      logic [1:0]  exp_resp;
      int          beat;
      bursts++;
      ar_id    <= id;
      ar_addr  <= addr;
      ar_len   <= len[`AXI_LEN_WIDTH-1:0];
      ar_burst <= burst;
      ar_valid <= 1'b1;
      do @(posedge clk); while (!ar_ready);
      ar_valid <= 1'b0;
      exp_resp = burst_ok(burst) ? axi_pkg::OKAY : axi_pkg::SLVERR;
      beat = 0;
      do begin
         r_ready <= ($urandom % 4 != 0);
         @(posedge clk);
         if (r_valid && r_ready) begin
            exp_data = burst_ok(burst) ? model_word(beat_word(addr, burst, beat)) : '0;
            check_val("r_data", r_data, exp_data);
            check_val("r_resp", 32'(r_resp), 32'(exp_resp));
            check_val("r_id", 32'(r_id), 32'(id));
            check_val("r_last", 32'(r_last), 32'(beat == len));
            beat++;
         end
      end while (!(r_valid && r_ready && r_last));
      r_ready <= 1'b0;
      check_val("r_beats", beat, len + 1);   // no lost or extra beat
   endtask

   task automatic report_test(input string name, input int start);
      tests++;
      $display("test %-12s done, %0d errors", name, errors - start);
   endtask

   initial begin
      int                         start;
      int                         len;
      int                         nbeats;
      logic [`AXI_ADDR_WIDTH-1:0] addr;
      logic [1:0]                 burst;
      void'($urandom(32'h1292d502));
      rstn     = 1'b0;
      aw_id    = '0;
      aw_addr  = '0;
      aw_len   = '0;
      aw_burst = '0;
      aw_valid = 1'b0;
      w_data   = '0;
      w_strb   = '0;
      w_last   = 1'b0;
      w_valid  = 1'b0;
      b_ready  = 1'b0;
      ar_id    = '0;
      ar_addr  = '0;
      ar_len   = '0;
      ar_burst = '0;
      ar_valid = 1'b0;
      r_ready  = 1'b0;
      repeat (8) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);

      start = errors;   // whole memory gets known contents
      write_burst(rand_id(), '0, 255, axi_pkg::INCR, 256, 1'b1);
      read_burst(rand_id(), '0, 255, axi_pkg::INCR);
      report_test("fill", start);

      start = errors;
      repeat (12) begin
         addr = rand_addr();
         len  = $urandom % 16;
         write_burst(rand_id(), addr, len, axi_pkg::INCR, len + 1, 1'b0);
         read_burst(rand_id(), addr, len, axi_pkg::INCR);
      end
      report_test("incr", start);

      start = errors;
      repeat (6) begin
         addr = rand_addr();
         len  = $urandom % 8;
         write_burst(rand_id(), addr, len, axi_pkg::FIXED, len + 1, 1'b0);
         read_burst(rand_id(), addr, len, axi_pkg::FIXED);
      end
      report_test("fixed", start);

      start = errors;
      for (int k = 0; k < 6; k++) begin
         addr  = rand_addr();
         len   = $urandom % 8;
         burst = (k % 2 == 0) ? axi_pkg::WRAP : axi_pkg::RSVD;
         write_burst(rand_id(), addr, len, burst, len + 1, 1'b0);
         read_burst(rand_id(), addr, len, burst);
         read_burst(rand_id(), addr, len, axi_pkg::INCR);   // memory untouched
      end
      report_test("unsupported", start);

      start = errors;
      for (int k = 0; k < 6; k++) begin
         addr   = rand_addr();
         len    = 1 + $urandom % 8;
         nbeats = (k % 2 == 0) ? len - ($urandom % len) : len + 2 + $urandom % 3;   // early, late
         write_burst(rand_id(), addr, len, axi_pkg::INCR, nbeats, 1'b0);
         read_burst(rand_id(), addr, nbeats - 1, axi_pkg::INCR);
      end
      report_test("w_last", start);

      errors += u_axi_ram.u_axi_ram_assert.fails;   // bound protocol properties
      $display("tests %0d, bursts %0d, checks %0d, errors %0d", tests, bursts, checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+src
src/axi_pkg.sv
src/ram_pkg.sv
src/req_fifo.sv
src/burst_counter.sv
src/ram_writer.sv
src/ram_reader.sv
src/ram_array.sv
src/axi_ram.sv
test/axi_ram_assert.sv
test/axi_ram_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile the axi_ram testbench with Verilator, run it and search the log for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f project.f --top-module axi_ram_tb \
   -Mdir obj_dir -o axi_ram_sim > build.log 2>&1 \
   && ./obj_dir/axi_ram_sim > sim.log 2>&1 \
   && grep -qxF '** PASS **' sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed, see build.log and sim.log"; exit 1; }
